/* hdl/qspi_pkg.sv */
package qspi_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [3:0]  count_t;     // 0 selects drain or fill

    typedef enum logic [1:0] {
        LANE_X1 = 2'd0,
        LANE_X2 = 2'd1,
        LANE_X4 = 2'd2
    } lane_width_e;

    typedef enum logic [1:0] {
        XFER_TX  = 2'd0,
        XFER_RX  = 2'd1,
        XFER_DMY = 2'd2
    } xfer_kind_e;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT_DONE, SEQ_FINISH} seq_state_e;
    typedef enum logic [1:0] {ENG_IDLE, ENG_TX, ENG_RX, ENG_DMY} eng_state_e;

    // register map
    localparam apb_addr_t REG_CTRL   = 4'h0;
    localparam apb_addr_t REG_TXD    = 4'h4;
    localparam apb_addr_t REG_RXD    = 4'h8;
    localparam apb_addr_t REG_STATUS = 4'hC;

    // ctrl fields
    localparam int CTRL_WIDTH_LSB   = 0;
    localparam int CTRL_DIR_BIT     = 2;
    localparam int CTRL_DUMMY_BIT   = 3;
    localparam int CTRL_COUNT_LSB   = 4;
    localparam int CTRL_PATTERN_LSB = 8;

    // status bits, 4 and 5 are write-one-to-clear strobes
    localparam int STAT_TX_NFULL  = 0;
    localparam int STAT_RX_NEMPTY = 1;
    localparam int STAT_BUSY      = 2;
    localparam int STAT_TX_EMPTY  = 3;
    localparam int STAT_TX_CLR    = 4;
    localparam int STAT_RX_CLR    = 5;

endpackage

/* hdl/qspi_byte_fifo.sv */
`timescale 1ns/1ps

module qspi_byte_fifo
    import qspi_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)(
    input  logic  clk,
    input  logic  rstn,
    input  logic  clr,
    input  logic  push,
    input  byte_t din,
    input  logic  pop,
    output byte_t dout,
    output logic  full,
    output logic  empty
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    byte_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn || clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !clr)
            mem[wr_ptr] <= din;
    end

endmodule

/* hdl/qspi_apb_regs.sv */
`timescale 1ns/1ps

module qspi_apb_regs
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        tx_push,
    output byte_t       tx_din,
    input  logic        tx_full,
    input  logic        tx_empty,
    output logic        tx_clr,
    output logic        rx_pop,
    input  byte_t       rx_head,
    input  logic        rx_empty,
    output logic        rx_clr,
    input  logic        busy,
    output logic        cmd_start,
    output xfer_kind_e  cmd_kind,
    output lane_width_e cmd_width,
    output count_t      cmd_count,
    output nibble_t     cmd_pattern
);
    logic       access;
    logic       sel_ctrl;
    logic       sel_txd;
    logic       sel_rxd;
    logic       sel_status;
    logic [1:0] wr_width;
    logic       wr_dir;
    logic       wr_dummy;
    count_t     wr_count;
    logic       bad_addr;
    logic       bad_dir;
    logic       bad_queue;
    logic       bad_ctrl;
    logic       ok;
    logic       ctrl_wr;

    assign access     = psel && penable;   // no wait states
    assign sel_ctrl   = (paddr == REG_CTRL);
    assign sel_txd    = (paddr == REG_TXD);
    assign sel_rxd    = (paddr == REG_RXD);
    assign sel_status = (paddr == REG_STATUS);

    assign wr_width = pwdata[CTRL_WIDTH_LSB +: 2];
    assign wr_dir   = pwdata[CTRL_DIR_BIT];
    assign wr_dummy = pwdata[CTRL_DUMMY_BIT];
    assign wr_count = pwdata[CTRL_COUNT_LSB +: 4];

    assign bad_addr  = !(sel_ctrl || sel_txd || sel_rxd || sel_status);
    assign bad_dir   = (sel_txd && !pwrite) || (sel_rxd && pwrite);
    assign bad_queue = (sel_txd && pwrite && tx_full) || (sel_rxd && !pwrite && rx_empty);
    assign bad_ctrl  = sel_ctrl && pwrite &&
                       (busy || (wr_width == 2'd3) || (wr_dummy && (wr_count == '0)));

    assign pready  = access;
    assign pslverr = access && (bad_addr || bad_dir || bad_queue || bad_ctrl);
    assign ok      = access && !pslverr;

    assign tx_push = ok && pwrite && sel_txd;
    assign tx_din  = pwdata[7:0];
    assign rx_pop  = ok && !pwrite && sel_rxd;
    assign tx_clr  = ok && pwrite && sel_status && pwdata[STAT_TX_CLR];
    assign rx_clr  = ok && pwrite && sel_status && pwdata[STAT_RX_CLR];
    assign ctrl_wr = ok && pwrite && sel_ctrl;

    // command fields hold until the next accepted ctrl write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmd_start   <= 1'b0;
            cmd_kind    <= XFER_TX;
            cmd_width   <= LANE_X1;
            cmd_count   <= '0;
            cmd_pattern <= '0;
        end else begin
            cmd_start <= ctrl_wr;
            if (ctrl_wr) begin
                cmd_kind    <= wr_dummy ? XFER_DMY : (wr_dir ? XFER_TX : XFER_RX);
                cmd_width   <= lane_width_e'(wr_width);
                cmd_count   <= wr_count;
                cmd_pattern <= pwdata[CTRL_PATTERN_LSB +: 4];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (ok && !pwrite) begin
            case (paddr)
                REG_CTRL: begin
                    prdata[CTRL_WIDTH_LSB +: 2]   = cmd_width;
                    prdata[CTRL_DIR_BIT]          = (cmd_kind == XFER_TX);
                    prdata[CTRL_DUMMY_BIT]        = (cmd_kind == XFER_DMY);
                    prdata[CTRL_COUNT_LSB +: 4]   = cmd_count;
                    prdata[CTRL_PATTERN_LSB +: 4] = cmd_pattern;
                end
                REG_RXD: prdata[7:0] = rx_head;
                REG_STATUS: begin
                    prdata[STAT_TX_NFULL]  = !tx_full;
                    prdata[STAT_RX_NEMPTY] = !rx_empty;
                    prdata[STAT_BUSY]      = busy;
                    prdata[STAT_TX_EMPTY]  = tx_empty;
                end
                default: prdata = '0;
            endcase
        end
    end

endmodule

/* hdl/qspi_xfer_seq.sv */
`timescale 1ns/1ps

module qspi_xfer_seq
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        cmd_start,
    input  xfer_kind_e  cmd_kind,
    input  lane_width_e cmd_width,
    input  count_t      cmd_count,
    input  nibble_t     cmd_pattern,
    output logic        busy,
    input  logic        tx_empty,
    input  logic        rx_full,
    input  byte_t       tx_head,
    output logic        tx_pop,
    output logic        rx_push,
    output logic        tx_req,
    output logic        rx_req,
    output logic        dmy_req,
    output lane_width_e width,
    output byte_t       tx_byte,
    output nibble_t     pattern,
    input  logic        tx_done,
    input  logic        rx_done,
    input  logic        dmy_done,
    output logic        qspi_csb
);
    seq_state_e state;
    count_t     remaining;
    logic       drain;
    logic       can_issue;
    logic       stop;
    logic       issue;
    logic       done_any;

    // command fields are stable while busy
    assign drain    = (cmd_count == '0);
    assign done_any = tx_done || rx_done || dmy_done;

    always_comb begin
        case (cmd_kind)
            XFER_TX: begin
                can_issue = !tx_empty;
                stop      = drain && tx_empty;
            end
            XFER_RX: begin
                can_issue = !rx_full;
                stop      = drain && rx_full;
            end
            default: begin
                can_issue = 1'b1;
                stop      = 1'b0;
            end
        endcase
    end

    assign issue   = (state == SEQ_ISSUE) && can_issue;
    assign tx_req  = issue && (cmd_kind == XFER_TX);
    assign rx_req  = issue && (cmd_kind == XFER_RX);
    assign dmy_req = issue && (cmd_kind == XFER_DMY);

    assign width   = cmd_width;
    assign pattern = cmd_pattern;
    assign tx_byte = tx_head;
    assign tx_pop  = tx_done;       // head leaves once shifted out
    assign rx_push = rx_done;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= SEQ_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (cmd_start) begin
                        state     <= SEQ_ISSUE;
                        remaining <= cmd_count;
                    end
                end
                SEQ_ISSUE: begin
                    if (stop)
                        state <= SEQ_FINISH;
                    else if (can_issue)
                        state <= SEQ_WAIT_DONE;
                end
                SEQ_WAIT_DONE: begin
                    if (done_any) begin
                        if (!drain && remaining == count_t'(1)) begin
                            state <= SEQ_FINISH;
                        end else begin
                            state     <= SEQ_ISSUE;
                            remaining <= remaining - 1'b1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // cs drops in the same cycle as cmd_start
    assign busy     = (state != SEQ_IDLE) || cmd_start;
    assign qspi_csb = !busy;

endmodule

/* hdl/qspi_io_engine.sv */
`timescale 1ns/1ps

module qspi_io_engine
    import qspi_pkg::*;
#(
    parameter logic SCLK_IDLE = 1'b0
)(
    input  logic        clk,
    input  logic        rstn,
    input  lane_width_e width,
    input  logic        tx_req,
    input  logic        rx_req,
    input  logic        dmy_req,
    input  byte_t       tx_byte,
    input  nibble_t     pattern,
    output logic        tx_done,
    output logic        rx_done,
    output logic        dmy_done,
    output byte_t       rx_byte,
    output logic        qspi_sclk,
    output nibble_t     qspi_dir,
    output nibble_t     qspi_mosi,
    input  nibble_t     qspi_miso
);
    eng_state_e  state;
    lane_width_e lane_w;
    logic        phase;      // 0 low half, 1 high half
    logic [2:0]  beat_cnt;   // beats left after this one
    logic        last_low;
    byte_t       tx_sh;
    nibble_t     pat_q;

    function automatic logic [2:0] last_beat(input lane_width_e w);
        case (w)
            LANE_X1: return 3'd7;
            LANE_X2: return 3'd3;
            default: return 3'd1;
        endcase
    endfunction

    assign last_low = (state != ENG_IDLE) && !phase && (beat_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ENG_IDLE;
            phase    <= 1'b0;
            beat_cnt <= '0;
            tx_done  <= 1'b0;
            rx_done  <= 1'b0;
            dmy_done <= 1'b0;
        end else begin
            tx_done  <= last_low && (state == ENG_TX);
            rx_done  <= last_low && (state == ENG_RX);
            dmy_done <= last_low && (state == ENG_DMY);
            if (state == ENG_IDLE) begin
                phase <= 1'b0;
                if (tx_req) begin
                    state    <= ENG_TX;
                    beat_cnt <= last_beat(width);
                end else if (rx_req) begin
                    state    <= ENG_RX;
                    beat_cnt <= last_beat(width);
                end else if (dmy_req) begin
                    state    <= ENG_DMY;
                    beat_cnt <= '0;    // one beat
                end
            end else if (!phase) begin
                phase <= 1'b1;
            end else begin
                phase <= 1'b0;
                if (beat_cnt == '0)
                    state <= ENG_IDLE;
                else
                    beat_cnt <= beat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ENG_IDLE) begin
            if (tx_req || rx_req || dmy_req) begin
                lane_w <= width;
                tx_sh  <= tx_byte;
                pat_q  <= pattern;
            end
        end else if (state == ENG_TX && phase) begin
            case (lane_w)
                LANE_X1: tx_sh <= {tx_sh[6:0], 1'b0};
                LANE_X2: tx_sh <= {tx_sh[5:0], 2'b00};
                default: tx_sh <= {tx_sh[3:0], 4'b0000};
            endcase
        end
        // sample at the end of the low half
        if (state == ENG_RX && !phase) begin
            case (lane_w)
                LANE_X1: rx_byte <= {rx_byte[6:0], qspi_miso[1]};
                LANE_X2: rx_byte <= {rx_byte[5:0], qspi_miso[1:0]};
                default: rx_byte <= {rx_byte[3:0], qspi_miso};
            endcase
        end
    end

    always_comb begin
        qspi_sclk = SCLK_IDLE;
        qspi_dir  = 4'b0000;
        qspi_mosi = 4'b0000;
        case (state)
            ENG_TX: begin
                qspi_sclk = phase;
                case (lane_w)
                    LANE_X1: begin
                        qspi_dir  = 4'b0001;
                        qspi_mosi = {3'b000, tx_sh[7]};
                    end
                    LANE_X2: begin
                        qspi_dir  = 4'b0011;
                        qspi_mosi = {2'b00, tx_sh[7:6]};
                    end
                    default: begin
                        qspi_dir  = 4'b1111;
                        qspi_mosi = tx_sh[7:4];
                    end
                endcase
            end
            ENG_RX: qspi_sclk = phase;
            ENG_DMY: begin
                qspi_sclk = phase;
                qspi_dir  = 4'b1111;   // dummy always drives the pattern
                qspi_mosi = pat_q;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/qspi_top.sv */
`timescale 1ns/1ps

module qspi_top
    import qspi_pkg::*;
#(
    parameter int   FIFO_DEPTH = 16,
    parameter logic SCLK_IDLE  = 1'b0
)(
    input  logic      clk,
    input  logic      rstn,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      qspi_csb,
    output logic      qspi_sclk,
    output nibble_t   qspi_dir,
    output nibble_t   qspi_mosi,
    input  nibble_t   qspi_miso
);
    logic        tx_push, tx_pop, tx_clr, tx_full, tx_empty;
    logic        rx_push, rx_pop, rx_clr, rx_full, rx_empty;
    byte_t       tx_din, tx_head, rx_head, rx_byte, tx_byte;
    logic        busy, cmd_start;
    xfer_kind_e  cmd_kind;
    lane_width_e cmd_width, width;
    count_t      cmd_count;
    nibble_t     cmd_pattern, pattern;
    logic        tx_req, rx_req, dmy_req;
    logic        tx_done, rx_done, dmy_done;

    qspi_apb_regs u_regs (
        .clk(clk), .rstn(rstn),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tx_push(tx_push), .tx_din(tx_din), .tx_full(tx_full), .tx_empty(tx_empty),
        .tx_clr(tx_clr), .rx_pop(rx_pop), .rx_head(rx_head), .rx_empty(rx_empty),
        .rx_clr(rx_clr), .busy(busy), .cmd_start(cmd_start), .cmd_kind(cmd_kind),
        .cmd_width(cmd_width), .cmd_count(cmd_count), .cmd_pattern(cmd_pattern)
    );

    qspi_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_txq (
        .clk(clk), .rstn(rstn), .clr(tx_clr), .push(tx_push), .din(tx_din),
        .pop(tx_pop), .dout(tx_head), .full(tx_full), .empty(tx_empty)
    );

    // filled by the engine through the sequencer
    qspi_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rxq (
        .clk(clk), .rstn(rstn), .clr(rx_clr), .push(rx_push), .din(rx_byte),
        .pop(rx_pop), .dout(rx_head), .full(rx_full), .empty(rx_empty)
    );

    qspi_xfer_seq u_seq (
        .clk(clk), .rstn(rstn), .cmd_start(cmd_start), .cmd_kind(cmd_kind),
        .cmd_width(cmd_width), .cmd_count(cmd_count), .cmd_pattern(cmd_pattern),
        .busy(busy), .tx_empty(tx_empty), .rx_full(rx_full), .tx_head(tx_head),
        .tx_pop(tx_pop), .rx_push(rx_push), .tx_req(tx_req), .rx_req(rx_req),
        .dmy_req(dmy_req), .width(width), .tx_byte(tx_byte), .pattern(pattern),
        .tx_done(tx_done), .rx_done(rx_done), .dmy_done(dmy_done), .qspi_csb(qspi_csb)
    );

    qspi_io_engine #(.SCLK_IDLE(SCLK_IDLE)) u_eng (
        .clk(clk), .rstn(rstn), .width(width),
        .tx_req(tx_req), .rx_req(rx_req), .dmy_req(dmy_req),
        .tx_byte(tx_byte), .pattern(pattern),
        .tx_done(tx_done), .rx_done(rx_done), .dmy_done(dmy_done), .rx_byte(rx_byte),
        .qspi_sclk(qspi_sclk), .qspi_dir(qspi_dir), .qspi_mosi(qspi_mosi),
        .qspi_miso(qspi_miso)
    );

endmodule

/* testbench/tb_qspi_top.sv */
`timescale 1ns/1ps

module tb_qspi_top
    import qspi_pkg::*;
;
    localparam int RESET_CYCLES = 5;

    logic      clk;
    logic      rstn;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      qspi_csb;
    logic      qspi_sclk;
    nibble_t   qspi_dir;
    nibble_t   qspi_mosi;
    nibble_t   qspi_miso;

    // stimulus table as parallel column queues
    string t_name[$];
    int    t_kind[$];      // 0 tx, 1 rx, 2 dummy, 3 drain tx
    int    t_width[$];
    int    t_count[$];
    int    t_nbytes[$];
    int    t_pattern[$];

    logic [16:0] lfsr_state = 17'd77235;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;

    // flash lane model state
    nibble_t cap_mosi[$];
    nibble_t cap_dir[$];
    byte_t   exp_rx[$];
    int      rx_w = 0;
    int      rx_beat = 0;
    logic    sclk_prev = 1'b0;

    qspi_top #(.FIFO_DEPTH(16), .SCLK_IDLE(1'b0)) dut0 (
        .clk(clk), .rstn(rstn), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .qspi_csb(qspi_csb), .qspi_sclk(qspi_sclk),
        .qspi_dir(qspi_dir), .qspi_mosi(qspi_mosi), .qspi_miso(qspi_miso)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    function automatic byte_t rand_byte();
        byte_t b;
        for (int i = 0; i < 8; i++)
            b = {b[6:0], lfsr_bit()};
        return b;
    endfunction

    function automatic int lane_bits(input int w);
        return (w == 0) ? 1 : (w == 1) ? 2 : 4;
    endfunction

    // msb-first miso lanes for one beat of the expected rx stream
    function automatic nibble_t miso_for(input int beat);
        int    bpb;
        int    bit_idx;
        byte_t b;
        bpb = lane_bits(rx_w);
        bit_idx = beat * bpb;
        if (bit_idx / 8 >= exp_rx.size())
            return 4'b0000;
        b = exp_rx[bit_idx / 8] << (bit_idx % 8);
        case (bpb)
            1: return {2'b00, b[7], 1'b0};
            2: return {2'b00, b[7:6]};
            default: return b[7:4];
        endcase
    endfunction

    always @(negedge clk) begin
        if (!qspi_csb && qspi_sclk && !sclk_prev) begin
            cap_mosi.push_back(qspi_mosi);
            cap_dir.push_back(qspi_dir);
            rx_beat++;
        end
        sclk_prev = qspi_sclk;
        qspi_miso = miso_for(rx_beat);
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error: %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #10;    // mid low half
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            errors++;
            $display("pready was not high in the access phase");
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (qspi_csb !== 1'b1)
            @(negedge clk);
    endtask

    task automatic add_entry(input string n, input int k, input int w, input int c,
                             input int nb, input int p);
        t_name.push_back(n);
        t_kind.push_back(k);
        t_width.push_back(w);
        t_count.push_back(c);
        t_nbytes.push_back(nb);
        t_pattern.push_back(p);
    endtask

    task automatic run_entry(input int i);
        apb_data_t rd;
        apb_data_t ctrl_wd;
        logic      err;
        byte_t     sent[$];
        byte_t     got;
        int        bpb;
        int        beats;
        int        exp_dir;
        string     n;
        n = t_name[i];
        bpb = lane_bits(t_width[i]);
        beats = 8 / bpb;
        cap_mosi.delete();
        cap_dir.delete();
        exp_rx.delete();
        rx_beat = 0;
        rx_w = t_width[i];
        case (t_kind[i])
            0, 3: begin
                for (int b = 0; b < t_nbytes[i]; b++) begin
                    sent.push_back(rand_byte());
                    apb_xfer(1'b1, REG_TXD, {24'd0, sent[b]}, rd, err);
                    check({n, " push err"}, 0, err);
                end
                ctrl_wd = (t_count[i] << 4) | 32'h4 | t_width[i];
                apb_xfer(1'b1, REG_CTRL, ctrl_wd, rd, err);
                check({n, " ctrl err"}, 0, err);
                wait_idle();
                check({n, " beats"}, t_nbytes[i] * beats, cap_mosi.size());
                exp_dir = (bpb == 1) ? 4'b0001 : (bpb == 2) ? 4'b0011 : 4'b1111;
                for (int b = 0; b < sent.size() && (b + 1) * beats <= cap_mosi.size(); b++) begin
                    got = '0;
                    for (int k = 0; k < beats; k++) begin
                        got = (got << bpb) | (cap_mosi[b * beats + k] & ((1 << bpb) - 1));
                        check({n, " dir"}, exp_dir, cap_dir[b * beats + k]);
                    end
                    check({n, " tx byte"}, sent[b], got);
                end
                apb_xfer(1'b0, REG_STATUS, '0, rd, err);
                check({n, " status after tx"}, 4'b1001, rd[3:0]);   // idle with tx empty
            end
            1: begin
                for (int b = 0; b < t_count[i]; b++)
                    exp_rx.push_back(rand_byte());
                ctrl_wd = (t_count[i] << 4) | t_width[i];
                apb_xfer(1'b1, REG_CTRL, ctrl_wd, rd, err);
                check({n, " ctrl err"}, 0, err);
                wait_idle();
                check({n, " beats"}, t_count[i] * beats, cap_dir.size());
                foreach (cap_dir[k])
                    check({n, " rx dir"}, 0, cap_dir[k]);
                for (int b = 0; b < t_count[i]; b++) begin
                    apb_xfer(1'b0, REG_RXD, '0, rd, err);
                    check({n, " rxd err"}, 0, err);
                    check({n, " rx byte"}, exp_rx[b], rd[7:0]);
                end
                apb_xfer(1'b0, REG_STATUS, '0, rd, err);
                check({n, " rx empty"}, 0, rd[1]);
            end
            default: begin
                ctrl_wd = (t_pattern[i] << 8) | (t_count[i] << 4) | 32'h8 | t_width[i];
                apb_xfer(1'b1, REG_CTRL, ctrl_wd, rd, err);
                check({n, " ctrl err"}, 0, err);
                wait_idle();
                check({n, " edges"}, t_count[i], cap_mosi.size());
                foreach (cap_mosi[k]) begin
                    check({n, " pattern"}, t_pattern[i], cap_mosi[k]);
                    check({n, " dir"}, 4'b1111, cap_dir[k]);
                end
            end
        endcase
        apb_xfer(1'b0, REG_CTRL, '0, rd, err);
        check({n, " ctrl readback"}, ctrl_wd, rd);
    endtask

    initial begin
        apb_data_t rd;
        logic      err;
        rstn = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        qspi_miso = '0;

        add_entry("tx_x1_c1", 0, 0, 1, 1, 0);
        add_entry("tx_x2_c2", 0, 1, 2, 2, 0);
        add_entry("tx_x4_c3", 0, 2, 3, 3, 0);
        add_entry("tx_x1_c4", 0, 0, 4, 4, 0);
        add_entry("tx_x4_c4", 0, 2, 4, 4, 0);
        add_entry("rx_x1_c2", 1, 0, 2, 2, 0);
        add_entry("rx_x2_c3", 1, 1, 3, 3, 0);
        add_entry("rx_x4_c4", 1, 2, 4, 4, 0);
        add_entry("dmy_c3_pa", 2, 0, 3, 3, 4'hA);
        add_entry("dmy_c1_pc", 2, 2, 1, 1, 4'hC);
        add_entry("drain_x2", 3, 1, 0, 5, 0);
        limit = RESET_CYCLES;
        foreach (t_count[i])
            limit += 16 * (t_count[i] + 1) * 4;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        check("reset status", 4'b1001, rd[3:0]);
        check("reset csb", 1, qspi_csb);
        apb_xfer(1'b0, REG_RXD, '0, rd, err);
        check("empty rxd err", 1, err);

        foreach (t_name[i])
            run_entry(i);

        // overfill the tx queue and clear it
        for (int b = 0; b < 17; b++) begin
            apb_xfer(1'b1, REG_TXD, b, rd, err);
            check("fill push err", (b == 16) ? 1 : 0, err);
        end
        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        check("full status", 4'b0000, rd[3:0]);
        apb_xfer(1'b1, REG_STATUS, 32'h10, rd, err);
        check("tx clear err", 0, err);
        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        check("cleared status", 4'b1001, rd[3:0]);

        // leave one received byte in the rx queue and clear it
        apb_xfer(1'b1, REG_CTRL, 32'h12, rd, err);
        check("rx fill ctrl err", 0, err);
        wait_idle();
        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        check("rx held status", 4'b1011, rd[3:0]);
        apb_xfer(1'b1, REG_STATUS, 32'h20, rd, err);
        check("rx clear err", 0, err);
        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        check("rx cleared status", 4'b1001, rd[3:0]);

        fork
            begin
                apb_xfer(1'b1, REG_CTRL, 32'h13, rd, err);   // width code 3
                check("width 3 err", 1, err);
                apb_xfer(1'b1, REG_CTRL, 32'h08, rd, err);   // dummy with count 0
                check("dummy count 0 err", 1, err);
                apb_xfer(1'b0, 4'h2, '0, rd, err);
                check("unmapped err", 1, err);
                repeat (3) @(negedge clk);
            end
            begin
                repeat (14) begin
                    @(negedge clk);
                    check("csb stays high", 1, qspi_csb);
                end
            end
        join

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* vlog.f */
hdl/qspi_pkg.sv
hdl/qspi_byte_fifo.sv
hdl/qspi_apb_regs.sv
hdl/qspi_xfer_seq.sv
hdl/qspi_io_engine.sv
hdl/qspi_top.sv
testbench/tb_qspi_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_qspi_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wall -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi; \
	if ! grep -qF '*** TEST PASSED ***' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
